/* src/rmt_pkg.sv */
package rmt_pkg;

	// pipeline geometry
	localparam int NUM_STAGES  = 3;
	localparam int TABLE_DEPTH = 4;

	// data word field positions
	localparam int KIND_LSB  = 56;
	localparam int KEY_LSB   = 48;
	localparam int VALUE_LSB = 32;
	localparam int TAG_LSB   = 8;
	localparam int CHECK_LSB = 0;

	// control word field positions
	localparam int CTL_STAGE_LSB   = 48;
	localparam int CTL_INDEX_LSB   = 40; // only low bits of the byte are used
	localparam int CTL_KEY_LSB     = 32;
	localparam int CTL_OPERAND_LSB = 16;
	localparam int CTL_ENABLE_BIT  = 8;

	typedef logic [7:0]  key_t;
	typedef logic [15:0] value_t;
	typedef logic [23:0] tag_t;
	typedef logic [7:0]  stage_id_t;
	typedef logic [1:0]  entry_idx_t;
	typedef logic [63:0] hdr_word_t;
	typedef logic [7:0]  check_t;

	// anything not listed here is dropped by the parser
	typedef enum logic [7:0] {
		KIND_DATA = 8'h11,
		KIND_CTRL = 8'hC0
	} pkt_kind_e;

	// header vector carried down the data path
	typedef struct packed {
		key_t   key;
		value_t value;
		tag_t   tag;
	} phv_t;

	// table update carried down the control path
	typedef struct packed {
		logic       valid;
		stage_id_t  stage_id;
		entry_idx_t index;
		key_t       match_key;
		value_t     operand;
		logic       enable;
	} ctl_t;

	// xor of bytes 7 down to 1
	function automatic check_t calc_check(input hdr_word_t w);
		check_t c;
		c = '0;
		for (int i = 1; i < 8; i++) begin
			c ^= w[i*8 +: 8];
		end
		return c;
	endfunction

endpackage

/* src/pkt_parser.sv */
`timescale 1ns/100ps

module pkt_parser (
	input  logic              clk,
	input  logic              aresetn,
	input  rmt_pkg::hdr_word_t in_data,
	input  logic              in_valid,
	output logic              in_ready,
	output rmt_pkg::phv_t     phv,
	output logic              phv_valid,
	input  logic              phv_ready,
	output rmt_pkg::ctl_t     ctl
);

	rmt_pkg::pkt_kind_e kind;
	rmt_pkg::check_t    check_rx;
	logic               check_ok;
	logic               in_fire;
	logic               take_data;
	logic               take_ctrl;
	rmt_pkg::phv_t      phv_next;
	rmt_pkg::ctl_t      ctl_next;

	// slot free or draining this cycle
	assign in_ready = !phv_valid || phv_ready;
	assign in_fire  = in_valid && in_ready;

	assign kind     = rmt_pkg::pkt_kind_e'(in_data[rmt_pkg::KIND_LSB +: 8]);
	assign check_rx = in_data[rmt_pkg::CHECK_LSB +: $bits(rmt_pkg::check_t)];
	assign check_ok = (check_rx == rmt_pkg::calc_check(in_data));

	// bad check byte drops the word whatever its kind
	always_comb begin
		take_data = 1'b0;
		take_ctrl = 1'b0;
		if (in_fire && check_ok) begin
			case (kind)
				rmt_pkg::KIND_DATA: take_data = 1'b1;
				rmt_pkg::KIND_CTRL: take_ctrl = 1'b1;
				default: ; // unknown kind, consumed silently
			endcase
		end
	end

	// data word fields
	assign phv_next.key   = in_data[rmt_pkg::KEY_LSB +: $bits(rmt_pkg::key_t)];
	assign phv_next.value = in_data[rmt_pkg::VALUE_LSB +: $bits(rmt_pkg::value_t)];
	assign phv_next.tag   = in_data[rmt_pkg::TAG_LSB +: $bits(rmt_pkg::tag_t)];

	// control word fields
	assign ctl_next.valid     = take_ctrl;
	assign ctl_next.stage_id  = in_data[rmt_pkg::CTL_STAGE_LSB +: $bits(rmt_pkg::stage_id_t)];
	assign ctl_next.index     = in_data[rmt_pkg::CTL_INDEX_LSB +: $bits(rmt_pkg::entry_idx_t)];
	assign ctl_next.match_key = in_data[rmt_pkg::CTL_KEY_LSB +: $bits(rmt_pkg::key_t)];
	assign ctl_next.operand   = in_data[rmt_pkg::CTL_OPERAND_LSB +: $bits(rmt_pkg::value_t)];
	assign ctl_next.enable    = in_data[rmt_pkg::CTL_ENABLE_BIT];

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			phv_valid <= 1'b0;
		end else if (take_data) begin
			phv_valid <= 1'b1;
		end else if (phv_ready) begin
			phv_valid <= 1'b0;
		end
	end

	// payload only loads on an accepted data word
	always_ff @(posedge clk) begin
		if (take_data) begin
			phv <= phv_next;
		end
	end

	// control update lives for one cycle
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			ctl <= '0;
		end else begin
			ctl <= ctl_next;
		end
	end

endmodule

/* src/match_stage.sv */
`timescale 1ns/100ps

module match_stage #(
	parameter rmt_pkg::stage_id_t STAGE_ID = '0
) (
	input  logic          clk,
	input  logic          aresetn,
	input  rmt_pkg::phv_t phv_in,
	input  logic          phv_in_valid,
	output logic          phv_in_ready,
	output rmt_pkg::phv_t phv_out,
	output logic          phv_out_valid,
	input  logic          phv_out_ready,
	input  rmt_pkg::ctl_t ctl_in,
	output rmt_pkg::ctl_t ctl_out
);

	localparam int DEPTH = rmt_pkg::TABLE_DEPTH;

	// match table
	logic [DEPTH-1:0] ent_en;
	rmt_pkg::key_t    ent_key [DEPTH];
	rmt_pkg::value_t  ent_op  [DEPTH];

	logic            ctl_hit;
	logic            in_fire;
	logic            hit;
	rmt_pkg::value_t hit_op;
	rmt_pkg::phv_t   phv_next;

	// update addressed to this stage
	assign ctl_hit = ctl_in.valid && (ctl_in.stage_id == STAGE_ID);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			ent_en <= '0; // all entries start disabled
		end else if (ctl_hit) begin
			ent_en[ctl_in.index] <= ctl_in.enable;
		end
	end

	always_ff @(posedge clk) begin
		if (ctl_hit) begin
			ent_key[ctl_in.index] <= ctl_in.match_key;
			ent_op[ctl_in.index]  <= ctl_in.operand;
		end
	end

	// lowest enabled index wins on duplicate keys
	always_comb begin
		hit    = 1'b0;
		hit_op = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (!hit && ent_en[i] && (ent_key[i] == phv_in.key)) begin
				hit    = 1'b1;
				hit_op = ent_op[i];
			end
		end
	end

	// miss adds zero, wraps mod 2^16
	always_comb begin
		phv_next       = phv_in;
		phv_next.value = phv_in.value + hit_op;
	end

	assign phv_in_ready = !phv_out_valid || phv_out_ready;
	assign in_fire      = phv_in_valid && phv_in_ready;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			phv_out_valid <= 1'b0;
		end else if (in_fire) begin
			phv_out_valid <= 1'b1;
		end else if (phv_out_ready) begin
			phv_out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			phv_out <= phv_next;
		end
	end

	// control path never stalls
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			ctl_out <= '0;
		end else begin
			ctl_out <= ctl_in;
		end
	end

endmodule

/* src/pkt_deparser.sv */
`timescale 1ns/100ps

module pkt_deparser (
	input  logic               clk,
	input  logic               aresetn,
	input  rmt_pkg::phv_t      phv,
	input  logic               phv_valid,
	output logic               phv_ready,
	output rmt_pkg::hdr_word_t out_data,
	output logic               out_valid,
	input  logic               out_ready
);

	rmt_pkg::hdr_word_t word;
	logic               in_fire;

	// rebuild data word, check byte over the finished upper bytes
	always_comb begin
		word = '0;
		word[rmt_pkg::KIND_LSB +: 8]                         = rmt_pkg::KIND_DATA;
		word[rmt_pkg::KEY_LSB +: $bits(rmt_pkg::key_t)]      = phv.key;
		word[rmt_pkg::VALUE_LSB +: $bits(rmt_pkg::value_t)]  = phv.value;
		word[rmt_pkg::TAG_LSB +: $bits(rmt_pkg::tag_t)]      = phv.tag;
		word[rmt_pkg::CHECK_LSB +: $bits(rmt_pkg::check_t)]  = rmt_pkg::calc_check(word);
	end

	assign phv_ready = !out_valid || out_ready;
	assign in_fire   = phv_valid && phv_ready;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			out_valid <= 1'b0;
		end else if (in_fire) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// held while downstream stalls
	always_ff @(posedge clk) begin
		if (in_fire) begin
			out_data <= word;
		end
	end

endmodule

/* src/rmt_top.sv */
`timescale 1ns/100ps

module rmt_top (
	input  logic               clk,
	input  logic               aresetn,
	input  rmt_pkg::hdr_word_t in_data,
	input  logic               in_valid,
	output logic               in_ready,
	output rmt_pkg::hdr_word_t out_data,
	output logic               out_valid,
	input  logic               out_ready
);

	localparam int N = rmt_pkg::NUM_STAGES;

	// link 0 from the parser, link N into the deparser
	rmt_pkg::phv_t phv_link [N+1];
	logic [N:0]    phv_link_valid;
	logic [N:0]    phv_link_ready;
	rmt_pkg::ctl_t ctl_link [N+1]; // last link ends here

	pkt_parser u_parser (
		.clk       (clk),
		.aresetn   (aresetn),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.phv       (phv_link[0]),
		.phv_valid (phv_link_valid[0]),
		.phv_ready (phv_link_ready[0]),
		.ctl       (ctl_link[0])
	);

	for (genvar g = 0; g < N; g++) begin : g_stage
		match_stage #(
			.STAGE_ID (rmt_pkg::stage_id_t'(g))
		) u_stage (
			.clk           (clk),
			.aresetn       (aresetn),
			.phv_in        (phv_link[g]),
			.phv_in_valid  (phv_link_valid[g]),
			.phv_in_ready  (phv_link_ready[g]),
			.phv_out       (phv_link[g+1]),
			.phv_out_valid (phv_link_valid[g+1]),
			.phv_out_ready (phv_link_ready[g+1]),
			.ctl_in        (ctl_link[g]),
			.ctl_out       (ctl_link[g+1])
		);
	end

	pkt_deparser u_deparser (
		.clk       (clk),
		.aresetn   (aresetn),
		.phv       (phv_link[N]),
		.phv_valid (phv_link_valid[N]),
		.phv_ready (phv_link_ready[N]),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic aresetn
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		aresetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(PERIOD_NS / 4);
		aresetn = 1'b1;
	end

endmodule

/* bench/rmt_tb.sv */
`timescale 1ns/100ps

module rmt_tb;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DLY   = 10;
	localparam int DRAIN_LIMIT = 400;
	localparam int BP_WORDS    = 64;
	localparam int STIM_WORDS  = 30 + BP_WORDS;
	localparam int WATCHDOG_CYCLES = STIM_WORDS * 20 + 500;
	localparam logic [31:0] SEED = 32'h9c522425;
	localparam int NS = rmt_pkg::NUM_STAGES;
	localparam int TD = rmt_pkg::TABLE_DEPTH;
	localparam rmt_pkg::key_t TEST_KEYS [5] = '{8'h10, 8'h20, 8'h30, 8'h40, 8'h10};

	logic               clk;
	logic               aresetn;
	rmt_pkg::hdr_word_t in_data;
	logic               in_valid;
	logic               in_ready;
	rmt_pkg::hdr_word_t out_data;
	logic               out_valid;
	logic               out_ready;
	logic               bp_random;

	// table model, same geometry as the DUT
	logic            tbl_en  [NS][TD];
	rmt_pkg::key_t   tbl_key [NS][TD];
	rmt_pkg::value_t tbl_op  [NS][TD];

	rmt_pkg::hdr_word_t exp_q [$];

	int mismatch_errs = 0;
	int other_errs    = 0;
	int mon_mismatch  = 0;
	int mon_other     = 0;

	clk_gen #(
		.PERIOD_NS    (CLK_PERIOD),
		.RESET_CYCLES (8)
	) u_clk_gen (
		.clk     (clk),
		.aresetn (aresetn)
	);

	rmt_top u_dut (
		.clk       (clk),
		.aresetn   (aresetn),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	// check byte is the xor of bytes 7 down to 1
	function automatic logic [7:0] xor_upper(input logic [63:0] w);
		logic [7:0] acc;
		acc = w[63:56];
		for (int b = 6; b >= 1; b--) begin
			acc = acc ^ w[b*8 +: 8];
		end
		return acc;
	endfunction

	function automatic rmt_pkg::hdr_word_t with_check(input rmt_pkg::hdr_word_t w);
		return {w[63:8], xor_upper(w)};
	endfunction

	function automatic rmt_pkg::hdr_word_t ctrl_word(input rmt_pkg::stage_id_t stage,
			input rmt_pkg::entry_idx_t idx, input rmt_pkg::key_t key,
			input rmt_pkg::value_t op, input logic en);
		return with_check({8'hC0, stage, 6'b0, idx, key, op, 7'b0, en, 8'h00});
	endfunction

	// first enabled hit per stage adds its operand
	function automatic rmt_pkg::value_t expected_value(input rmt_pkg::key_t key,
			input rmt_pkg::value_t value);
		rmt_pkg::value_t v;
		v = value;
		for (int s = 0; s < NS; s++) begin
			for (int i = 0; i < TD; i++) begin
				if (tbl_en[s][i] && tbl_key[s][i] == key) begin
					v = v + tbl_op[s][i];
					break;
				end
			end
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			mismatch_errs++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// called and returns a little after a rising edge, valid left high
	task automatic send_word(input rmt_pkg::hdr_word_t w);
		logic accepted;
		accepted = 1'b0;
		in_data  = w;
		in_valid = 1'b1;
		while (!accepted) begin
			@(negedge clk);
			accepted = in_ready; // transfer at the coming edge
			@(posedge clk);
			#DRIVE_DLY;
		end
	endtask

	task automatic send_data(input rmt_pkg::key_t key, input rmt_pkg::value_t value,
			input rmt_pkg::tag_t tag);
		exp_q.push_back(with_check({8'h11, key, expected_value(key, value), tag, 8'h00}));
		send_word(with_check({8'h11, key, value, tag, 8'h00}));
	endtask

	task automatic send_ctrl(input rmt_pkg::stage_id_t stage, input rmt_pkg::entry_idx_t idx,
			input rmt_pkg::key_t key, input rmt_pkg::value_t op, input logic en);
		int s;
		s = int'(stage);
		if (s < NS) begin
			tbl_en[s][idx]  = en;
			tbl_key[s][idx] = key;
			tbl_op[s][idx]  = op;
		end
		send_word(ctrl_word(stage, idx, key, op, en));
	endtask

	task automatic idle_cycle();
		in_valid = 1'b0;
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic drain();
		int waited;
		waited   = 0;
		in_valid = 1'b0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			other_errs++;
			$display("pipeline did not drain, %0d words never came out", exp_q.size());
		end
		repeat (8) @(posedge clk); // lets control words finish too
		#DRIVE_DLY;
	endtask

	task automatic reset_state_test();
		@(negedge clk);
		check_value("out_valid", 64'(out_valid), 64'd0);
		check_value("in_ready", 64'(in_ready), 64'd1);
		@(posedge clk);
		#DRIVE_DLY;
		for (int n = 0; n < 4; n++) begin
			send_data(8'($urandom), 16'($urandom), 24'($urandom));
		end
		drain();
	endtask

	task automatic filter_test();
		rmt_pkg::hdr_word_t w;
		send_data(8'h5C, 16'h1000, 24'hA1A2A3);
		w = with_check({8'h11, 8'h5C, 16'h2000, 24'hB1B2B3, 8'h00});
		send_word(w ^ 64'h1);                    // data with bad check
		send_word(with_check({8'h5A, 8'h5C, 16'h3000, 24'hC1C2C3, 8'h00}));
		send_ctrl(8'h07, 2'd0, 8'h5C, 16'h0001, 1'b1); // no such stage
		w = ctrl_word(8'h00, 2'd0, 8'h5C, 16'h0100, 1'b1);
		send_word(w ^ 64'h80);                   // would hit 5C if taken
		send_data(8'h5C, 16'h4000, 24'hD1D2D3);
		send_data(8'($urandom), 16'($urandom), 24'($urandom));
		drain();
	endtask

	task automatic table_test();
		send_ctrl(8'd0, 2'd0, 8'h10, 16'h0100, 1'b1);
		send_ctrl(8'd0, 2'd2, 8'h10, 16'h7000, 1'b1); // duplicate, higher index
		send_ctrl(8'd1, 2'd1, 8'h20, 16'h0005, 1'b1);
		send_ctrl(8'd1, 2'd3, 8'h10, 16'h0020, 1'b1);
		send_ctrl(8'd2, 2'd3, 8'h10, 16'hFFFF, 1'b1); // wraps the value
		send_ctrl(8'd2, 2'd0, 8'h30, 16'h1234, 1'b1);
		drain();
		for (int n = 0; n < 5; n++) begin
			send_data(TEST_KEYS[n], 16'hFF80 + 16'(n), 24'($urandom));
		end
		drain();
		// disabled entries stop matching
		send_ctrl(8'd0, 2'd0, 8'h10, 16'h0100, 1'b0);
		send_ctrl(8'd2, 2'd0, 8'h30, 16'h1234, 1'b0);
		drain();
		for (int n = 0; n < 5; n++) begin
			send_data(TEST_KEYS[n], 16'($urandom), 24'($urandom));
		end
		drain();
	endtask

	task automatic latency_test();
		int edges;
		edges = 1; // the accepting edge is the first
		send_data(8'h77, 16'h0042, 24'h123456);
		in_valid = 1'b0;
		while (edges < 20) begin
			@(negedge clk);
			if (out_valid) begin
				break;
			end
			@(posedge clk);
			edges++;
		end
		check_value("latency in edges", 64'(edges), 64'd5);
		drain();
	endtask

	task automatic backpressure_test();
		rmt_pkg::key_t key;
		int            k;
		bp_random = 1'b1;
		for (int n = 0; n < BP_WORDS; n++) begin
			k = int'($urandom % 5);
			if ($urandom % 2 == 0) begin
				key = TEST_KEYS[k];
			end else begin
				key = 8'($urandom);
			end
			send_data(key, 16'($urandom), 24'($urandom));
			if ($urandom % 4 == 0) begin
				idle_cycle();
			end
		end
		drain();
		bp_random = 1'b0;
	endtask

	// sink side, changes only a little after the rising edge
	initial begin
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			#DRIVE_DLY;
			if (bp_random) begin
				out_ready = ($urandom % 3) != 0;
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	// output monitor, samples mid cycle
	logic               stall_seen = 1'b0;
	rmt_pkg::hdr_word_t stall_data;
	rmt_pkg::hdr_word_t exp_word;

	always @(negedge clk) begin
		if (aresetn) begin
			if (stall_seen) begin
				assert (out_valid) else begin
					mon_other++;
					$display("out_valid dropped at %0t while out_ready was low", $time);
				end
				assert (out_data === stall_data) else begin
					mon_mismatch++;
					$display("mismatch at %0t: out_data held got %h expected %h",
						$time, out_data, stall_data);
				end
			end
			if (out_valid && out_ready) begin
				assert (exp_q.size() > 0) else begin
					mon_other++;
					$display("unexpected output word %h at %0t", out_data, $time);
				end
				if (exp_q.size() > 0) begin
					exp_word = exp_q.pop_front();
					assert (out_data === exp_word) else begin
						mon_mismatch++;
						$display("mismatch at %0t: out_data got %h expected %h",
							$time, out_data, exp_word);
					end
				end
			end
			stall_seen = out_valid && !out_ready;
			stall_data = out_data;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("errors: %0d mismatch, %0d other", mismatch_errs + mon_mismatch,
			other_errs + mon_other + 1);
		$display("Test failed");
		$finish;
	end

	initial begin
		in_data   = '0;
		in_valid  = 1'b0;
		bp_random = 1'b0;
		for (int s = 0; s < NS; s++) begin
			for (int i = 0; i < TD; i++) begin
				tbl_en[s][i]  = 1'b0;
				tbl_key[s][i] = '0;
				tbl_op[s][i]  = '0;
			end
		end
		void'($urandom(SEED));
		wait (aresetn === 1'b1);
		@(posedge clk);
		#DRIVE_DLY;

		reset_state_test();
		filter_test();
		table_test();
		latency_test();
		backpressure_test();

		$display("errors: %0d mismatch, %0d other", mismatch_errs + mon_mismatch,
			other_errs + mon_other);
		if (mismatch_errs + mon_mismatch + other_errs + mon_other == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* build.f */
src/rmt_pkg.sv
src/pkt_parser.sv
src/match_stage.sv
src/pkt_deparser.sv
src/rmt_top.sv
bench/clk_gen.sv
bench/rmt_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module rmt_tb -o rmt_sim

./obj_dir/rmt_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "run.sh: simulation passed"
	exit 0
else
	echo "run.sh: simulation did not pass, see sim.log"
	exit 1
fi
